//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- include/mem_fill.svh
// Word held by memory at a byte address that was never written
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b9) ^ 32'h5a3c_0f96;
endfunction

//--- bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    `include "mem_fill.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 200;
    // Directed requests plus the random ones, each bounded generously
    localparam int NUM_REQS     = NUM_RANDOM + 30;
    localparam int REQ_CYCLES   = 40;

    logic    clk = 1'b0;
    logic    resetn;
    logic    valid;
    logic    op;
    tag_t    tag;
    index_t  index;
    offset_t offset;
    wstrb_t  wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    line_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    word_t exp_mem [addr_t];
    string test_name = "reset";
    int    rd_count  = 0;
    int    wb_count  = 0;
    addr_t wb_addr   = '0;
    addr_t req_addr  = '0;
    int    seed;

    dcache uut (.*);

    mem_model mem (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic addr_t make_addr(tag_t t, index_t i, bank_t b);
        return {t, i, b, 2'b00};
    endfunction

    function automatic word_t expected_word(addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        if (exp_mem.exists(w)) begin
            return exp_mem[w];
        end
        return fill_word(w);
    endfunction

    function automatic line_t line_image(addr_t a);
        line_t l;
        for (int b = 0; b < BANKS; b++) begin
            l[b*WORD_W +: WORD_W] = expected_word({a[31:4], 4'h0} + addr_t'(4 * b));
        end
        return l;
    endfunction

    task automatic record_store(addr_t a, wstrb_t s, word_t d);
        word_t w;
        w = expected_word(a);
        for (int i = 0; i < WORD_W / 8; i++) begin
            if (s[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        exp_mem[{a[31:2], 2'b00}] = w;
    endtask

    task automatic expect_equal(string what, line_t expected, line_t actual);
        if (expected !== actual) begin
            $display("Error in %s (%s): expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch in test %s", test_name);
        end
    endtask

    task automatic drive_request(logic st, addr_t a, wstrb_t s, word_t d);
        req_addr = a;
        valid    = 1'b1;
        op       = st;
        tag      = a[31 -: TAG_W];
        index    = a[OFFSET_W +: INDEX_W];
        offset   = a[OFFSET_W-1:0];
        wstrb    = s;
        wdata    = d;
    endtask

    // Both waits sample 1 ns after the falling edge
    task automatic wait_accept();
        #1;
        while (!addr_ok) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic access(input logic st, input addr_t a, input wstrb_t s, input word_t d,
                          output word_t rd, output int lat);
        @(negedge clk);
        drive_request(st, a, s, d);
        wait_accept();
        @(negedge clk);
        valid = 1'b0;
        #1;
        lat = 1;
        while (!data_ok) begin
            @(negedge clk);
            #1;
            lat++;
        end
        rd = rdata;
        if (st) begin
            record_store(a, s, d);
        end
    endtask

    task automatic load(input addr_t a, output int lat);
        word_t rd;
        access(1'b0, a, '0, '0, rd, lat);
        expect_equal("load data", line_t'(expected_word(a)), line_t'(rd));
    endtask

    task automatic store(input addr_t a, input wstrb_t s, input word_t d);
        word_t rd;
        int    lat;
        access(1'b1, a, s, d, rd, lat);
    endtask

    task automatic miss_then_hit();
        addr_t a;
        int    lat;
        test_name = "load_miss_hit";
        a = make_addr(20'h12345, 8'h01, 2'd2);
        load(a, lat);
        load(a, lat);
        expect_equal("hit latency", line_t'(1), line_t'(lat));
        load(a + 32'h4, lat);
        expect_equal("other bank hit latency", line_t'(1), line_t'(lat));
    endtask

    task automatic forward_partial_store();
        addr_t a;
        int    lat;
        test_name = "store_forward";
        a = make_addr(20'h00abc, 8'h02, 2'd1);
        load(a, lat);
        @(negedge clk);
        drive_request(1'b1, a, 4'b0101, 32'hdead_beef);
        wait_accept();
        // Load rides right behind the store hit
        @(negedge clk);
        drive_request(1'b0, a, '0, '0);
        #1;
        expect_equal("store data_ok", line_t'(1), line_t'(data_ok));
        expect_equal("load accepted behind store", line_t'(1), line_t'(addr_ok));
        record_store(a, 4'b0101, 32'hdead_beef);
        @(negedge clk);
        valid = 1'b0;
        #1;
        expect_equal("load data_ok", line_t'(1), line_t'(data_ok));
        expect_equal("forwarded word", line_t'(expected_word(a)), line_t'(rdata));
        load(a, lat);
    endtask

    task automatic refill_merges_store();
        addr_t a;
        int    lat;
        test_name = "store_miss";
        a = make_addr(20'h00777, 8'h03, 2'd0);
        store(a, 4'b1100, 32'h1234_5678);
        load(a, lat);
        expect_equal("merged word hits", line_t'(1), line_t'(lat));
        load(a + 32'h8, lat);
    endtask

    task automatic dirty_victim_write_back();
        addr_t a1;
        addr_t a2;
        addr_t a3;
        int    lat;
        int    n;
        test_name = "write_back";
        a1 = make_addr(20'h01000, 8'h04, 2'd0);
        a2 = make_addr(20'h02000, 8'h04, 2'd3);
        a3 = make_addr(20'h03000, 8'h04, 2'd1);
        store(a1, 4'hf, 32'h1111_1111);
        store(a2, 4'b0011, 32'h2222_2222);
        // Way1 becomes the recently hit way, so way0 goes out
        load(a2, lat);
        n = wb_count;
        load(a3, lat);
        expect_equal("write-back count", line_t'(n + 1), line_t'(wb_count));
        expect_equal("write-back address", line_t'({a1[31:4], 4'h0}), line_t'(wb_addr));
        load(a1, lat);
    endtask

    task automatic recent_hit_replacement();
        addr_t u1;
        addr_t u2;
        addr_t u3;
        int    lat;
        int    n;
        test_name = "replacement";
        u1 = make_addr(20'h04000, 8'h05, 2'd0);
        u2 = make_addr(20'h05000, 8'h05, 2'd1);
        u3 = make_addr(20'h06000, 8'h05, 2'd2);
        load(u1, lat);
        load(u2, lat);
        load(u1, lat);
        load(u3, lat);
        n = rd_count;
        load(u1, lat);
        expect_equal("way0 line kept", line_t'(n), line_t'(rd_count));
        expect_equal("way0 line hit latency", line_t'(1), line_t'(lat));
        load(u2, lat);
        expect_equal("way1 line evicted", line_t'(n + 1), line_t'(rd_count));
    endtask

    task automatic random_traffic();
        addr_t  a;
        logic   st;
        wstrb_t s;
        word_t  d;
        int     lat;
        test_name = "random";
        for (int k = 0; k < NUM_RANDOM; k++) begin
            a  = make_addr(tag_t'(20'h0a000 + ($random(seed) & 3)),
                           index_t'(8'h10 + ($random(seed) & 3)), bank_t'($random(seed)));
            st = 1'($random(seed));
            s  = wstrb_t'($random(seed));
            d  = $random(seed);
            if (s == '0) begin
                s = 4'hf;
            end
            if (st) begin
                store(a, s, d);
            end else begin
                load(a, lat);
            end
        end
    endtask

    // Bus monitor checks each refill address and write-back line
    always @(negedge clk) begin
        #1;
        if (resetn && rd_req && rd_rdy) begin
            rd_count++;
            expect_equal("refill address", line_t'({req_addr[31:4], 4'h0}), line_t'(rd_addr));
        end
        if (resetn && wr_req && wr_rdy) begin
            wb_count++;
            wb_addr = wr_addr;
            expect_equal("write-back line", line_image(wr_addr), wr_data);
        end
    end

    initial begin
        #((RESET_CYCLES + 10 + NUM_REQS * REQ_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        seed   = 32'ha344_cd75;
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        tag    = '0;
        index  = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        miss_then_hit();
        forward_partial_store();
        refill_merges_store();
        dirty_victim_write_back();
        recent_hit_replacement();
        random_traffic();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  dcache_pkg::addr_t rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output dcache_pkg::line_t ret_data,
    input  logic              wr_req,
    input  dcache_pkg::addr_t wr_addr,
    input  dcache_pkg::line_t wr_data,
    output logic              wr_rdy
);
    import dcache_pkg::*;

    `include "mem_fill.svh"

    // Return comes 0 to 3 cycles after the read is taken
    localparam int MAX_RET_WAIT = 3;

    int    seed;
    line_t shadow [addr_t];
    logic  pending;
    int    ret_wait;
    addr_t ret_addr;

    function automatic line_t read_line(addr_t a);
        line_t l;
        if (shadow.exists(a)) begin
            l = shadow[a];
        end else begin
            for (int b = 0; b < BANKS; b++) begin
                l[b*WORD_W +: WORD_W] = fill_word(a + addr_t'(4 * b));
            end
        end
        return l;
    endfunction

    initial begin
        seed      = 32'ha344_cd75;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        pending   = 1'b0;
        ret_wait  = 0;
        ret_addr  = '0;
        forever begin
            @(negedge clk);
            ret_valid = 1'b0;
            if (!resetn) begin
                rd_rdy  = 1'b0;
                wr_rdy  = 1'b0;
                pending = 1'b0;
            end else begin
                if (pending) begin
                    if (ret_wait == 0) begin
                        ret_valid = 1'b1;
                        ret_data  = read_line(ret_addr);
                        pending   = 1'b0;
                    end else begin
                        ret_wait--;
                    end
                end
                // Ready three cycles in four
                rd_rdy = ($random(seed) & 3) != 0;
                wr_rdy = ($random(seed) & 3) != 0;
                // Both handshakes complete at the coming rising edge
                if (rd_req && rd_rdy && !pending) begin
                    pending  = 1'b1;
                    ret_addr = rd_addr;
                    ret_wait = $random(seed) & MAX_RET_WAIT;
                end
                if (wr_req && wr_rdy) begin
                    shadow[wr_addr] = wr_data;
                end
            end
        end
    end

endmodule

//--- hw/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                op,
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::wstrb_t  wstrb,
    input  dcache_pkg::word_t   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    output logic                rd_req,
    output dcache_pkg::addr_t   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  dcache_pkg::line_t   ret_data,
    output logic                wr_req,
    output dcache_pkg::addr_t   wr_addr,
    output dcache_pkg::line_t   wr_data,
    input  logic                wr_rdy
);
    import dcache_pkg::*;

    logic       way0_lookup_en,    way1_lookup_en;
    index_t     way0_lookup_index, way1_lookup_index;
    logic       way0_store_en,     way1_store_en;
    index_t     way0_store_index,  way1_store_index;
    bank_t      way0_store_bank,   way1_store_bank;
    wstrb_t     way0_store_wstrb,  way1_store_wstrb;
    word_t      way0_store_wdata,  way1_store_wdata;
    logic       way0_refill_en,    way1_refill_en;
    index_t     way0_refill_index, way1_refill_index;
    tag_t       way0_refill_tag,   way1_refill_tag;
    line_t      way0_refill_line,  way1_refill_line;
    logic       way0_refill_dirty, way1_refill_dirty;
    tag_t       way0_tag_out,      way1_tag_out;
    logic       way0_valid_out,    way1_valid_out;
    logic       way0_dirty_out,    way1_dirty_out;
    line_t      way0_line_out,     way1_line_out;

    // Victim selector handshake
    logic       hit_en;
    logic       miss_en;
    way_t       hit_way;
    way_t       victim_way;
    index_t     set_index;
    logic [1:0] way_valid;
    logic [1:0] way_dirty;

    dcache_ctrl u_ctrl (.*);

    dcache_victim u_victim (.*);

    dcache_way way0 (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_en    (way0_lookup_en),
        .lookup_index (way0_lookup_index),
        .store_en     (way0_store_en),
        .store_index  (way0_store_index),
        .store_bank   (way0_store_bank),
        .store_wstrb  (way0_store_wstrb),
        .store_wdata  (way0_store_wdata),
        .refill_en    (way0_refill_en),
        .refill_index (way0_refill_index),
        .refill_tag   (way0_refill_tag),
        .refill_line  (way0_refill_line),
        .refill_dirty (way0_refill_dirty),
        .tag_out      (way0_tag_out),
        .valid_out    (way0_valid_out),
        .dirty_out    (way0_dirty_out),
        .line_out     (way0_line_out)
    );

    dcache_way way1 (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_en    (way1_lookup_en),
        .lookup_index (way1_lookup_index),
        .store_en     (way1_store_en),
        .store_index  (way1_store_index),
        .store_bank   (way1_store_bank),
        .store_wstrb  (way1_store_wstrb),
        .store_wdata  (way1_store_wdata),
        .refill_en    (way1_refill_en),
        .refill_index (way1_refill_index),
        .refill_tag   (way1_refill_tag),
        .refill_line  (way1_refill_line),
        .refill_dirty (way1_refill_dirty),
        .tag_out      (way1_tag_out),
        .valid_out    (way1_valid_out),
        .dirty_out    (way1_dirty_out),
        .line_out     (way1_line_out)
    );

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                op,
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::wstrb_t  wstrb,
    input  dcache_pkg::word_t   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    output logic                rd_req,
    output dcache_pkg::addr_t   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  dcache_pkg::line_t   ret_data,
    output logic                wr_req,
    output dcache_pkg::addr_t   wr_addr,
    output dcache_pkg::line_t   wr_data,
    input  logic                wr_rdy,
    output logic                way0_lookup_en,
    output dcache_pkg::index_t  way0_lookup_index,
    output logic                way0_store_en,
    output dcache_pkg::index_t  way0_store_index,
    output dcache_pkg::bank_t   way0_store_bank,
    output dcache_pkg::wstrb_t  way0_store_wstrb,
    output dcache_pkg::word_t   way0_store_wdata,
    output logic                way0_refill_en,
    output dcache_pkg::index_t  way0_refill_index,
    output dcache_pkg::tag_t    way0_refill_tag,
    output dcache_pkg::line_t   way0_refill_line,
    output logic                way0_refill_dirty,
    input  dcache_pkg::tag_t    way0_tag_out,
    input  logic                way0_valid_out,
    input  logic                way0_dirty_out,
    input  dcache_pkg::line_t   way0_line_out,
    output logic                way1_lookup_en,
    output dcache_pkg::index_t  way1_lookup_index,
    output logic                way1_store_en,
    output dcache_pkg::index_t  way1_store_index,
    output dcache_pkg::bank_t   way1_store_bank,
    output dcache_pkg::wstrb_t  way1_store_wstrb,
    output dcache_pkg::word_t   way1_store_wdata,
    output logic                way1_refill_en,
    output dcache_pkg::index_t  way1_refill_index,
    output dcache_pkg::tag_t    way1_refill_tag,
    output dcache_pkg::line_t   way1_refill_line,
    output logic                way1_refill_dirty,
    input  dcache_pkg::tag_t    way1_tag_out,
    input  logic                way1_valid_out,
    input  logic                way1_dirty_out,
    input  dcache_pkg::line_t   way1_line_out,
    output logic                hit_en,
    output dcache_pkg::way_t    hit_way,
    output logic                miss_en,
    output dcache_pkg::index_t  set_index,
    output logic [1:0]          way_valid,
    output logic [1:0]          way_dirty,
    input  dcache_pkg::way_t    victim_way
);
    import dcache_pkg::*;

    main_state_t state, next_state;
    wbuf_state_t wb_state;

    logic    rb_op;
    tag_t    rb_tag;
    index_t  rb_index;
    offset_t rb_offset;
    wstrb_t  rb_wstrb;
    word_t   rb_wdata;
    bank_t   rb_bank;

    way_t    wb_way;
    index_t  wb_index;
    bank_t   wb_bank;
    wstrb_t  wb_wstrb;
    word_t   wb_wdata;

    logic [1:0] way_hit;
    logic [1:0] fwd_hit;
    line_t      fwd_line [2];
    line_t      hit_line;
    line_t      refill_data;
    line_t      sel_line;
    logic       cache_hit;
    logic       accept;
    logic       store_hit;
    logic       write_back;

    tag_t       mb_tag  [2];
    line_t      mb_line [2];
    logic [1:0] mb_valid;
    logic [1:0] mb_dirty;

    function automatic line_t merge_line(line_t line, bank_t bank, wstrb_t strb, word_t data);
        line_t res;
        res = line;
        for (int i = 0; i < WORD_W / 8; i++) begin
            if (strb[i]) begin
                res[bank*WORD_W + 8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign accept  = valid && addr_ok;
    assign addr_ok = valid && (state == IDLE || (state == LOOKUP && cache_hit));
    assign rb_bank = rb_offset[OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (accept) begin
            rb_op     <= op;
            rb_tag    <= tag;
            rb_index  <= index;
            rb_offset <= offset;
            rb_wstrb  <= wstrb;
            rb_wdata  <= wdata;
        end
    end

    // Tag compare and write-buffer forwarding into the lookup data
    assign way_valid  = {way1_valid_out, way0_valid_out};
    assign way_hit[0] = way_valid[0] && (way0_tag_out == rb_tag);
    assign way_hit[1] = way_valid[1] && (way1_tag_out == rb_tag);
    assign cache_hit  = |way_hit;
    assign fwd_hit[0] = (wb_state == WB_WRITE) && !wb_way && (wb_index == rb_index);
    assign fwd_hit[1] = (wb_state == WB_WRITE) && wb_way && (wb_index == rb_index);
    assign fwd_line[0] = fwd_hit[0] ? merge_line(way0_line_out, wb_bank, wb_wstrb, wb_wdata)
                                    : way0_line_out;
    assign fwd_line[1] = fwd_hit[1] ? merge_line(way1_line_out, wb_bank, wb_wstrb, wb_wdata)
                                    : way1_line_out;
    assign way_dirty   = {way1_dirty_out, way0_dirty_out} | fwd_hit;
    assign hit_line    = way_hit[1] ? fwd_line[1] : fwd_line[0];

    assign refill_data = rb_op ? merge_line(ret_data, rb_bank, rb_wstrb, rb_wdata) : ret_data;
    assign sel_line    = (state == REFILL) ? refill_data : hit_line;
    assign rdata       = sel_line[rb_bank*WORD_W +: WORD_W];
    assign data_ok     = (state == LOOKUP && cache_hit) || (state == REFILL && ret_valid);

    assign hit_en    = (state == LOOKUP) && cache_hit;
    assign miss_en   = (state == LOOKUP) && !cache_hit;
    assign hit_way   = way_hit[1];
    assign set_index = rb_index;
    assign store_hit = hit_en && rb_op;

    always_ff @(posedge clk) begin
        if (store_hit) begin
            wb_way   <= way_hit[1];
            wb_index <= rb_index;
            wb_bank  <= rb_bank;
            wb_wstrb <= rb_wstrb;
            wb_wdata <= rb_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_state <= WB_IDLE;
        end else begin
            wb_state <= store_hit ? WB_WRITE : WB_IDLE;
        end
    end

    // Miss buffer
    always_ff @(posedge clk) begin
        if (miss_en) begin
            mb_tag[0]  <= way0_tag_out;
            mb_tag[1]  <= way1_tag_out;
            mb_line[0] <= fwd_line[0];
            mb_line[1] <= fwd_line[1];
            mb_valid   <= way_valid;
            mb_dirty   <= way_dirty;
        end
    end

    assign write_back = mb_valid[victim_way] && mb_dirty[victim_way];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept) next_state = LOOKUP;
            LOOKUP:  next_state = !cache_hit ? MISS : (accept ? LOOKUP : IDLE);
            MISS:    if (!write_back || wr_rdy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {rb_tag, rb_index, {OFFSET_W{1'b0}}};
    assign wr_req  = (state == MISS) && write_back;
    assign wr_addr = {mb_tag[victim_way], rb_index, {OFFSET_W{1'b0}}};
    assign wr_data = mb_line[victim_way];

    assign way0_lookup_en    = accept;
    assign way1_lookup_en    = accept;
    assign way0_lookup_index = index;
    assign way1_lookup_index = index;

    // Buffered store commit
    assign way0_store_en    = (wb_state == WB_WRITE) && !wb_way;
    assign way1_store_en    = (wb_state == WB_WRITE) && wb_way;
    assign way0_store_index = wb_index;
    assign way1_store_index = wb_index;
    assign way0_store_bank  = wb_bank;
    assign way1_store_bank  = wb_bank;
    assign way0_store_wstrb = wb_wstrb;
    assign way1_store_wstrb = wb_wstrb;
    assign way0_store_wdata = wb_wdata;
    assign way1_store_wdata = wb_wdata;

    assign way0_refill_en    = (state == REFILL) && ret_valid && !victim_way;
    assign way1_refill_en    = (state == REFILL) && ret_valid && victim_way;
    assign way0_refill_index = rb_index;
    assign way1_refill_index = rb_index;
    assign way0_refill_tag   = rb_tag;
    assign way1_refill_tag   = rb_tag;
    assign way0_refill_line  = refill_data;
    assign way1_refill_line  = refill_data;
    assign way0_refill_dirty = rb_op;
    assign way1_refill_dirty = rb_op;

    a_single_hit: assert property (@(posedge clk) disable iff (!resetn)
        (state == LOOKUP) |-> !(way_hit[0] && way_hit[1]));
    a_one_bus_req: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req));
    a_ret_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> (state == REFILL));

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int NUM_SETS = 256;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;
    localparam int BANKS    = 4;
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 128;

    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [OFFSET_W-1:0]      offset_t;
    typedef logic [$clog2(BANKS)-1:0] bank_t;
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [WORD_W/8-1:0]      wstrb_t;

    // Bank 0 sits in the low bits
    typedef logic [LINE_W-1:0] line_t;

    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;
    typedef logic                              way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_t;

    typedef enum logic {
        WB_IDLE,
        WB_WRITE
    } wbuf_state_t;

endpackage

//--- hw/dcache_victim.sv
`timescale 1ns/1ps

module dcache_victim (
    input  logic               clk,
    input  logic               resetn,
    input  logic               hit_en,
    input  dcache_pkg::way_t   hit_way,
    input  logic               miss_en,
    input  dcache_pkg::index_t set_index,
    input  logic [1:0]         way_valid,
    input  logic [1:0]         way_dirty,
    output dcache_pkg::way_t   victim_way
);
    import dcache_pkg::*;

    // Way that hit most recently in each set
    logic [NUM_SETS-1:0] recent;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            recent <= '0;
        end else if (hit_en) begin
            recent[set_index] <= hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_way <= 1'b0;
        end else if (miss_en) begin
            if (!way_valid[0]) begin
                victim_way <= 1'b0;
            end else if (!way_valid[1]) begin
                victim_way <= 1'b1;
            end else if (way_dirty[0] != way_dirty[1]) begin
                // Pick the clean one
                victim_way <= way_dirty[0];
            end else begin
                victim_way <= ~recent[set_index];
            end
        end
    end

endmodule

//--- hw/dcache_way.sv
`timescale 1ns/1ps

module dcache_way (
    input  logic               clk,
    input  logic               resetn,
    input  logic               lookup_en,
    input  dcache_pkg::index_t lookup_index,
    input  logic               store_en,
    input  dcache_pkg::index_t store_index,
    input  dcache_pkg::bank_t  store_bank,
    input  dcache_pkg::wstrb_t store_wstrb,
    input  dcache_pkg::word_t  store_wdata,
    input  logic               refill_en,
    input  dcache_pkg::index_t refill_index,
    input  dcache_pkg::tag_t   refill_tag,
    input  dcache_pkg::line_t  refill_line,
    input  logic               refill_dirty,
    output dcache_pkg::tag_t   tag_out,
    output logic               valid_out,
    output logic               dirty_out,
    output dcache_pkg::line_t  line_out
);
    import dcache_pkg::*;

    tag_t                tag_mem  [NUM_SETS];
    word_t               bank_mem [BANKS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;
    index_t              index_r;

    // Lookup read port
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            tag_out <= tag_mem[lookup_index];
            index_r <= lookup_index;
            for (int b = 0; b < BANKS; b++) begin
                line_out[b*WORD_W +: WORD_W] <= bank_mem[b][lookup_index];
            end
            // Store landing in the same cycle wins over the old bytes
            if (store_en && store_index == lookup_index) begin
                for (int i = 0; i < WORD_W / 8; i++) begin
                    if (store_wstrb[i]) begin
                        line_out[store_bank*WORD_W + 8*i +: 8] <= store_wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // Write port for refills and buffered stores
    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_mem[refill_index] <= refill_tag;
            for (int b = 0; b < BANKS; b++) begin
                bank_mem[b][refill_index] <= refill_line[b*WORD_W +: WORD_W];
            end
        end else if (store_en) begin
            for (int i = 0; i < WORD_W / 8; i++) begin
                if (store_wstrb[i]) begin
                    bank_mem[store_bank][store_index][8*i +: 8] <= store_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_out  <= 1'b0;
        end else begin
            if (refill_en) begin
                valid_bits[refill_index] <= 1'b1;
                dirty_bits[refill_index] <= refill_dirty;
            end else if (store_en) begin
                dirty_bits[store_index] <= 1'b1;
            end
            if (lookup_en) begin
                valid_out <= valid_bits[lookup_index];
            end
        end
    end

    // Live read so later stores show up
    assign dirty_out = dirty_bits[index_r];

    a_one_writer: assert property (@(posedge clk) disable iff (!resetn)
        !(store_en && refill_en));

endmodule

//--- sources.f
+incdir+include
hw/dcache_pkg.sv
hw/dcache_way.sv
hw/dcache_victim.sv
hw/dcache_ctrl.sv
hw/dcache.sv
bench/mem_model.sv
bench/dcache_tb.sv
